//--- all.f
source/frontend_pkg.sv
source/iq_pkg.sv
source/inst_rom.sv
source/fetch_unit.sv
source/inst_queue.sv
source/frontend_top.sv
verif/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - files:
      - source/frontend_pkg.sv
      - source/iq_pkg.sv
  - files:
      - source/inst_rom.sv
      - source/fetch_unit.sv
      - source/inst_queue.sv
      - source/frontend_top.sv
  - target: test
    files:
      - verif/frontend_tb.sv

//--- program.hex
// one 32-bit instruction word per line, in hex
// line n holds the word at byte address 4*n
00100093
00200113
002081b3
40110233
0041f2b3
0051e333
005343b3
00439413
0013d493
00a00513
fff50513
fe051ee3
00b12023
00012583
00c58613
00d60693
00e68713
00f70793
01078813
01180893
01288913
01390993
01498a13
015a0a93
016a8b13
017b0b93
018b8c13
019c0c93
01ac8d13
01bd0d93
01cd8e13
0000006f

//--- verif/frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_tb;

    localparam int          ROM_WORDS     = 32;
    localparam int          IQ_DEPTH      = 8;
    localparam logic [31:0] ROM_BYTES     = ROM_WORDS * 4;
    localparam logic [31:0] LFSR_SEED     = 32'h5a4e_5ad1;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
    localparam int          ROUNDS        = 8;
    localparam int          RANDOM_CYCLES = 60;
    localparam int          POP_TARGET    = 200;
    localparam int          REDIRECT_MIN  = 4;

    logic                       clk;
    logic                       arst_n;
    logic                       redirect;
    frontend_pkg::pc_t          redirect_pc;
    logic                       pop_1;
    logic                       pop_2;
    frontend_pkg::fetch_entry_t entry_1;
    frontend_pkg::fetch_entry_t entry_2;
    logic                       ok_1;
    logic                       ok_2;
    logic                       stall;

    frontend_pkg::inst_t model_mem [ROM_WORDS];
    frontend_pkg::pc_t   exp_pc;
    logic [31:0]         lfsr_state;
    int                  pop_count;
    int                  redirect_count;

    frontend_top #(
        .ROM_WORDS (ROM_WORDS),
        .IQ_DEPTH  (IQ_DEPTH)
    ) frontend_top_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pop_1       (pop_1),
        .pop_2       (pop_2),
        .entry_1     (entry_1),
        .entry_2     (entry_2),
        .ok_1        (ok_1),
        .ok_2        (ok_2),
        .stall       (stall)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end else begin
            return s >> 1;
        end
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] wrap_pc(input logic [31:0] pc);
        return pc % ROM_BYTES;
    endfunction

    function automatic logic [31:0] model_inst(input logic [31:0] pc);
        return model_mem[(pc >> 2) % ROM_WORDS];
    endfunction

    task automatic fail_plain(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] time %0t ns signal %s expected %h actual %h",
                 $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // expected pc at the head moves on with each pop
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_pc         <= frontend_pkg::RESET_PC;
            pop_count      <= 0;
            redirect_count <= 0;
        end else if (redirect) begin
            exp_pc         <= {redirect_pc[31:2], 2'b00};
            redirect_count <= redirect_count + 1;
        end else if (pop_1 && pop_2 && ok_1 && ok_2) begin
            exp_pc    <= wrap_pc(exp_pc + 32'd8);
            pop_count <= pop_count + 2;
        end else if (pop_1 && !pop_2 && ok_1) begin
            exp_pc    <= wrap_pc(exp_pc + 32'd4);
            pop_count <= pop_count + 1;
        end
    end

    a_reset_quiet: assert property (@(negedge clk) !arst_n |-> !stall && !ok_1 && !ok_2)
        else fail_plain("stall or an ok level was high during reset");

    a_release_quiet: assert property (
        @(posedge clk) $rose(arst_n) |-> !stall && !ok_1 && !ok_2
    ) else fail_plain("stall or an ok level was high in the first cycle after reset");

    a_first_ok: assert property (@(posedge clk) $rose(arst_n) |=> ok_1)
        else fail_plain("ok_1 was not high one cycle after reset release");

    a_first_pc: assert property (
        @(posedge clk) $rose(arst_n) |=> entry_1.pc == frontend_pkg::RESET_PC
    ) else report_mismatch("entry_1.pc", frontend_pkg::RESET_PC, $sampled(entry_1.pc));

    a_entry_1_pc: assert property (
        @(posedge clk) disable iff (!arst_n) ok_1 |-> entry_1.pc == exp_pc
    ) else report_mismatch("entry_1.pc", $sampled(exp_pc), $sampled(entry_1.pc));

    a_entry_1_inst: assert property (
        @(posedge clk) disable iff (!arst_n) ok_1 |-> entry_1.inst == model_inst(exp_pc)
    ) else report_mismatch("entry_1.inst", model_inst($sampled(exp_pc)),
                           $sampled(entry_1.inst));

    a_entry_2_pc: assert property (
        @(posedge clk) disable iff (!arst_n) ok_2 |-> entry_2.pc == wrap_pc(exp_pc + 32'd4)
    ) else report_mismatch("entry_2.pc", wrap_pc($sampled(exp_pc) + 32'd4),
                           $sampled(entry_2.pc));

    a_entry_2_inst: assert property (
        @(posedge clk) disable iff (!arst_n)
        ok_2 |-> entry_2.inst == model_inst(wrap_pc(exp_pc + 32'd4))
    ) else report_mismatch("entry_2.inst", model_inst(wrap_pc($sampled(exp_pc) + 32'd4)),
                           $sampled(entry_2.inst));

    // a stalled queue is nearly full
    a_stall_ok_2: assert property (
        @(posedge clk) disable iff (!arst_n) (stall && !redirect) |-> ok_2
    ) else report_mismatch("ok_2", 32'd1, 32'($sampled(ok_2)));

    a_redirect_quiet: assert property (
        @(posedge clk) disable iff (!arst_n) redirect |-> !ok_1 && !ok_2
    ) else fail_plain("an ok level was high in a redirect cycle");

    task automatic wait_for_stall(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (stall !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (stall !== level) begin
            fail_plain($sformatf("stall did not go to %0b within %0d cycles", level, limit));
        end
    endtask

    task automatic wait_for_ok_1(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (ok_1 !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (ok_1 !== 1'b1) begin
            fail_plain($sformatf("ok_1 did not rise within %0d cycles", limit));
        end
    endtask

    task automatic drive_random_cycle();
        @(posedge clk);
        pop_1 <= (draw_bits(2) != 0);
        pop_2 <= (draw_bits(1) != 0);
        // rare redirect
        if (draw_bits(6) == 0) begin
            redirect    <= 1'b1;
            redirect_pc <= draw_bits(5) << 2;
        end else begin
            redirect <= 1'b0;
        end
    endtask

    task automatic back_pressure();
        @(posedge clk);
        pop_1    <= 1'b0;
        pop_2    <= 1'b0;
        redirect <= 1'b0;
        wait_for_stall(1'b1, 24);
        repeat (3) @(posedge clk);
        @(posedge clk);
        pop_1 <= 1'b1;
        pop_2 <= (draw_bits(1) != 0);
        wait_for_stall(1'b0, 24);
    endtask

    task automatic issue_redirect(input logic odd_word);
        logic [31:0] word;
        word = draw_bits(5);
        if (odd_word) begin
            word[0] = 1'b1;
        end
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= word << 2;
        pop_1       <= (draw_bits(1) != 0);
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        pop_1       = 1'b0;
        pop_2       = 1'b0;
        lfsr_state  = LFSR_SEED;
        $readmemh("program.hex", model_mem);
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        wait_for_ok_1(10);
        for (int r = 0; r < ROUNDS; r++) begin
            repeat (RANDOM_CYCLES) drive_random_cycle();
            back_pressure();
            issue_redirect(r[0]);
        end
        repeat (20) drive_random_cycle();
        @(posedge clk);
        pop_1    <= 1'b0;
        pop_2    <= 1'b0;
        redirect <= 1'b0;
        @(negedge clk);
        if (pop_count >= POP_TARGET && redirect_count >= REDIRECT_MIN) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_plain($sformatf("run ended with only %0d pops and %0d redirects",
                                 pop_count, redirect_count));
        end
    end

endmodule

`default_nettype wire

//--- source/frontend_top.sv
`timescale 1ns/10ps
`default_nettype none

module frontend_top #(
    parameter int ROM_WORDS = 32,
    parameter int IQ_DEPTH  = 8
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       redirect,
    input  frontend_pkg::pc_t          redirect_pc,
    input  logic                       pop_1,
    input  logic                       pop_2,
    output frontend_pkg::fetch_entry_t entry_1,
    output frontend_pkg::fetch_entry_t entry_2,
    output logic                       ok_1,
    output logic                       ok_2,
    output logic                       stall
);

    frontend_pkg::pc_t          rom_addr_1;
    frontend_pkg::pc_t          rom_addr_2;
    frontend_pkg::inst_t        rom_inst_1;
    frontend_pkg::inst_t        rom_inst_2;
    logic                       w_ena_1;
    logic                       w_ena_2;
    frontend_pkg::fetch_entry_t w_data_1;
    frontend_pkg::fetch_entry_t w_data_2;

    inst_rom #(
        .ROM_WORDS (ROM_WORDS)
    ) inst_rom_inst (
        .clk    (clk),
        .addr_1 (rom_addr_1),
        .addr_2 (rom_addr_2),
        .inst_1 (rom_inst_1),
        .inst_2 (rom_inst_2)
    );

    fetch_unit #(
        .ROM_WORDS (ROM_WORDS)
    ) fetch_unit_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rom_addr_1  (rom_addr_1),
        .rom_addr_2  (rom_addr_2),
        .rom_inst_1  (rom_inst_1),
        .rom_inst_2  (rom_inst_2),
        .w_ena_1     (w_ena_1),
        .w_ena_2     (w_ena_2),
        .w_data_1    (w_data_1),
        .w_data_2    (w_data_2)
    );

    // redirect doubles as the queue flush
    inst_queue #(
        .IQ_DEPTH (IQ_DEPTH),
        .entry_t  (frontend_pkg::fetch_entry_t)
    ) inst_queue_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (redirect),
        .pop_1    (pop_1),
        .pop_2    (pop_2),
        .w_ena_1  (w_ena_1),
        .w_ena_2  (w_ena_2),
        .w_data_1 (w_data_1),
        .w_data_2 (w_data_2),
        .entry_1  (entry_1),
        .entry_2  (entry_2),
        .ok_1     (ok_1),
        .ok_2     (ok_2),
        .stall    (stall)
    );

endmodule

`default_nettype wire

//--- source/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue #(
    parameter int  IQ_DEPTH = 8,
    parameter type entry_t  = frontend_pkg::fetch_entry_t
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flush,
    input  logic   pop_1,
    input  logic   pop_2,
    input  logic   w_ena_1,
    input  logic   w_ena_2,
    input  entry_t w_data_1,
    input  entry_t w_data_2,
    output entry_t entry_1,
    output entry_t entry_2,
    output logic   ok_1,
    output logic   ok_2,
    output logic   stall
);

    localparam int IDX = $clog2(IQ_DEPTH);

    typedef logic [IDX:0] ptr_t;

    entry_t mem [IQ_DEPTH];
    entry_t wait_1;
    entry_t wait_2;

    ptr_t w_ptr;
    ptr_t r_ptr;
    ptr_t w_ptr_p1;
    ptr_t r_ptr_p1;
    ptr_t count;
    logic full;
    logic empty;
    logic left_one;

    iq_pkg::append_state_t state;
    iq_pkg::append_state_t state_nxt;

    logic       wr_1;
    logic       wr_2;
    entry_t     wr_data_1;
    entry_t     wr_data_2;
    logic       load_w1;
    logic       load_w2;
    entry_t     w1_src;
    logic [1:0] w_adv;
    logic [1:0] r_adv;
    logic [1:0] offer_cnt;
    logic [1:0] parked_cnt;

    // full when the wrap bits differ and the indices match
    assign w_ptr_p1 = w_ptr + ptr_t'(1);
    assign r_ptr_p1 = r_ptr + ptr_t'(1);
    assign count    = w_ptr - r_ptr;
    assign empty    = (w_ptr == r_ptr);
    assign full     = (w_ptr[IDX] != r_ptr[IDX]) && (w_ptr[IDX-1:0] == r_ptr[IDX-1:0]);
    assign left_one = (w_ptr_p1[IDX] != r_ptr[IDX]) && (w_ptr_p1[IDX-1:0] == r_ptr[IDX-1:0]);

    assign entry_1 = mem[r_ptr[IDX-1:0]];
    assign entry_2 = mem[r_ptr_p1[IDX-1:0]];
    assign ok_1    = ~empty & ~flush;
    assign ok_2    = ~empty & (r_ptr_p1 != w_ptr) & ~flush;
    assign stall   = (state != iq_pkg::IQ_NORMAL);

    // space is judged before this cycle's pops
    always_comb begin
        state_nxt = state;
        wr_1      = 1'b0;
        wr_2      = 1'b0;
        wr_data_1 = w_data_1;
        wr_data_2 = w_data_2;
        load_w1   = 1'b0;
        load_w2   = 1'b0;
        w1_src    = w_data_1;
        if (!flush) begin
            case (state)
                iq_pkg::IQ_NORMAL: begin
                    if (w_ena_1) begin
                        if (full) begin
                            load_w1   = 1'b1;
                            load_w2   = w_ena_2;
                            state_nxt = w_ena_2 ? iq_pkg::IQ_WAIT_2 : iq_pkg::IQ_WAIT_1;
                        end else if (w_ena_2 && left_one) begin
                            wr_1      = 1'b1;
                            load_w1   = 1'b1;
                            w1_src    = w_data_2;
                            state_nxt = iq_pkg::IQ_WAIT_1;
                        end else begin
                            wr_1 = 1'b1;
                            wr_2 = w_ena_2;
                        end
                    end
                end
                iq_pkg::IQ_WAIT_1: begin
                    if (!full) begin
                        wr_1      = 1'b1;
                        wr_data_1 = wait_1;
                        state_nxt = iq_pkg::IQ_NORMAL;
                    end
                end
                iq_pkg::IQ_WAIT_2: begin
                    // with one slot free the older entry drains and the younger stays parked
                    if (left_one) begin
                        wr_1      = 1'b1;
                        wr_data_1 = wait_1;
                        load_w1   = 1'b1;
                        w1_src    = wait_2;
                        state_nxt = iq_pkg::IQ_WAIT_1;
                    end else if (!full) begin
                        wr_1      = 1'b1;
                        wr_2      = 1'b1;
                        wr_data_1 = wait_1;
                        wr_data_2 = wait_2;
                        state_nxt = iq_pkg::IQ_NORMAL;
                    end
                end
                default: begin
                    state_nxt = iq_pkg::IQ_NORMAL;
                end
            endcase
        end
    end

    assign w_adv = {1'b0, wr_1} + {1'b0, wr_2};

    always_comb begin
        if (pop_1 && pop_2 && ok_1 && ok_2) begin
            r_adv = 2'd2;
        end else if (pop_1 && !pop_2 && ok_1) begin
            r_adv = 2'd1;
        end else begin
            r_adv = 2'd0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_ptr <= '0;
            r_ptr <= '0;
            state <= iq_pkg::IQ_NORMAL;
        end else if (flush) begin
            w_ptr <= '0;
            r_ptr <= '0;
            state <= iq_pkg::IQ_NORMAL;
        end else begin
            w_ptr <= w_ptr + ptr_t'(w_adv);
            r_ptr <= r_ptr + ptr_t'(r_adv);
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_1) begin
            mem[w_ptr[IDX-1:0]] <= wr_data_1;
        end
        if (wr_2) begin
            mem[w_ptr_p1[IDX-1:0]] <= wr_data_2;
        end
        if (load_w1) begin
            wait_1 <= w1_src;
        end
        if (load_w2) begin
            wait_2 <= w_data_2;
        end
    end

    assign offer_cnt  = {1'b0, w_ena_1} + {1'b0, w_ena_1 & w_ena_2};
    assign parked_cnt = (state == iq_pkg::IQ_WAIT_2) ? 2'd2 :
                        (state == iq_pkg::IQ_WAIT_1) ? 2'd1 : 2'd0;

    a_occupancy: assert property (
        @(posedge clk) disable iff (!arst_n) count <= ptr_t'(IQ_DEPTH)
    );

    a_ptr_forward: assert property (
        @(posedge clk) disable iff (!arst_n)
        !flush |=> (ptr_t'(w_ptr - $past(w_ptr)) <= ptr_t'(2)) &&
                   (ptr_t'(r_ptr - $past(r_ptr)) <= ptr_t'(2))
    );

    // every offer taken in IQ_NORMAL is either written or parked
    a_no_drop: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == iq_pkg::IQ_NORMAL && !flush) |=>
            (ptr_t'(w_ptr - $past(w_ptr)) + ptr_t'(parked_cnt)) == ptr_t'($past(offer_cnt))
    );

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter int ROM_WORDS = 32
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       stall,
    input  logic                       redirect,
    input  frontend_pkg::pc_t          redirect_pc,
    output frontend_pkg::pc_t          rom_addr_1,
    output frontend_pkg::pc_t          rom_addr_2,
    input  frontend_pkg::inst_t        rom_inst_1,
    input  frontend_pkg::inst_t        rom_inst_2,
    output logic                       w_ena_1,
    output logic                       w_ena_2,
    output frontend_pkg::fetch_entry_t w_data_1,
    output frontend_pkg::fetch_entry_t w_data_2
);

    localparam frontend_pkg::pc_t ROM_BYTES = frontend_pkg::pc_t'(ROM_WORDS * 4);

    frontend_pkg::pc_t pc;
    frontend_pkg::pc_t pc_plus_4;
    frontend_pkg::pc_t boundary;
    frontend_pkg::pc_t next_pc;

    assign pc_plus_4 = pc + 32'd4;

    // start of the next 8-byte packet wrapped to the rom image
    assign boundary = {pc[31:3], 3'b000} + 32'd8;
    assign next_pc  = boundary % ROM_BYTES;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= frontend_pkg::RESET_PC;
        end else if (redirect) begin
            pc <= {redirect_pc[31:2], 2'b00};
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    assign rom_addr_1 = pc;
    assign rom_addr_2 = pc_plus_4;

    // packet in the redirect cycle is stale, so it is not offered
    assign w_ena_1 = ~redirect;
    // odd word of a pair has no partner in this packet
    assign w_ena_2 = ~redirect & ~pc[2];

    assign w_data_1 = '{pc: pc, inst: rom_inst_1};
    assign w_data_2 = '{pc: pc_plus_4, inst: rom_inst_2};

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    );

    a_slot_order: assert property (
        @(posedge clk) disable iff (!arst_n) w_ena_2 |-> w_ena_1
    );

    // the held packet must be the one the queue sees once stall drops
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n) (stall && !redirect) |=> $stable(pc)
    );

endmodule

`default_nettype wire

//--- source/inst_rom.sv
`timescale 1ns/10ps
`default_nettype none

module inst_rom #(
    parameter int ROM_WORDS = 32
) (
    input  logic                clk,
    input  frontend_pkg::pc_t   addr_1,
    input  frontend_pkg::pc_t   addr_2,
    output frontend_pkg::inst_t inst_1,
    output frontend_pkg::inst_t inst_2
);

    localparam int IDX_W = $clog2(ROM_WORDS);

    frontend_pkg::inst_t mem [ROM_WORDS];

    logic [IDX_W-1:0] idx_1;
    logic [IDX_W-1:0] idx_2;

    initial begin
        $readmemh("program.hex", mem);
    end

    // word index, wrapping at the image size
    assign idx_1 = IDX_W'((addr_1 >> 2) % ROM_WORDS);
    assign idx_2 = IDX_W'((addr_2 >> 2) % ROM_WORDS);

    assign inst_1 = mem[idx_1];
    assign inst_2 = mem[idx_2];

    // fetch must never hand out a byte or halfword address
    a_word_aligned: assert property (
        @(posedge clk) (addr_1[1:0] == 2'b00) && (addr_2[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

//--- source/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // how many offered entries sit in the wait registers
    typedef enum logic [1:0] {
        IQ_NORMAL = 2'b00,
        IQ_WAIT_1 = 2'b01,
        IQ_WAIT_2 = 2'b10
    } append_state_t;

endpackage

`default_nettype wire

//--- source/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // one queue entry with pc in the upper half
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_entry_t;

    // first pc fetched out of reset
    localparam pc_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
